// File: vlog.f
+incdir+common
common/periph_pkg.sv
rtl/periph_bus_adapter.sv
rtl/periph_decode.sv
timer/periph_timer.sv
irq/periph_irq_ctrl.sv
rtl/periph_subsystem.sv
verification/periph_subsystem_assertions.sv
verification/periph_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module periph_subsystem_tb
out=$(./obj_dir/Vperiph_subsystem_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "TEST PASS"

// File: verification/periph_subsystem_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the peripheral subsystem with bus stimulus, read checks,
// per-test report and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_subsystem_tb;

  localparam int clk_period    = 100;
  localparam int drive_delay   = 10;
  localparam int reset_cycles  = 16;
  // Cycle budget of each test in order
  localparam int test_cycles   = 24 + 16 + 36 + 4 * 22 + 12 + 6;
  localparam int margin_cycles = 100;
  localparam periph_pkg::slot_t irq_slot = periph_pkg::slot_t'(`PERIPH_IRQ_SLOT);

  logic                           clk;
  logic                           rst_n;
  logic                           bus_req;
  logic [`PERIPH_ADDR_W-1:0]      bus_addr;
  logic                           bus_we;
  logic [`PERIPH_DATA_W-1:0]      bus_wdata;
  logic                           bus_gnt;
  logic                           bus_rvalid;
  logic [`PERIPH_DATA_W-1:0]      bus_rdata;
  logic [`PERIPH_NUM_EXT_INT-1:0] intr_ext;
  logic                           irq;
  logic                           msip;

  logic [31:0] rng_state = 32'ha4f3;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          mark;

  periph_subsystem dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .bus_req_i    (bus_req),
    .bus_addr_i   (bus_addr),
    .bus_we_i     (bus_we),
    .bus_wdata_i  (bus_wdata),
    .bus_gnt_o    (bus_gnt),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata),
    .intr_ext_i   (intr_ext),
    .irq_o        (irq),
    .msip_o       (msip)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #((reset_cycles + test_cycles + margin_cycles) * clk_period);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [`PERIPH_ADDR_W-1:0] reg_addr(periph_pkg::slot_t slot,
                                                         periph_pkg::reg_idx_t idx);
    logic [`PERIPH_ADDR_W-1:0] addr;
    addr = '0;
    addr[`PERIPH_SLOT_LSB +: `PERIPH_SLOT_W] = slot;
    addr[`PERIPH_REG_LSB +: `PERIPH_REG_W] = idx;
    return addr;
  endfunction

  function automatic int fail_total();
    return errors + int'(dut_i.assertions_i.fail_count);
  endfunction

  // Starts 10 ns after an edge and returns 10 ns after the next one
  task automatic access(input logic we, input periph_pkg::slot_t slot,
                        input periph_pkg::reg_idx_t idx, input logic [31:0] wdata,
                        output logic [31:0] rdata);
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = reg_addr(slot, idx);
    bus_wdata = wdata;
    @(posedge clk);
    #(drive_delay);
    bus_req = 1'b0;
    if (!bus_rvalid) begin
      errors++;
      $display("No read-valid one cycle after the grant at %0t", $time);
    end
    rdata = bus_rdata;
  endtask

  task automatic check_value(logic [31:0] got, logic [31:0] exp, string what);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(periph_pkg::slot_t slot, periph_pkg::reg_idx_t idx,
                           logic [31:0] wdata);
    logic [31:0] ignored;
    access(1'b1, slot, idx, wdata, ignored);
  endtask

  task automatic check_reg(periph_pkg::slot_t slot, periph_pkg::reg_idx_t idx,
                           logic [31:0] exp, string what);
    logic [31:0] got;
    access(1'b0, slot, idx, '0, got);
    check_value(got, exp, what);
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (fail_total() != mark) begin
      tests_failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
    mark = fail_total();
  endtask

  initial begin
    logic [31:0] val;
    logic [31:0] src;
    int          c;
    int          waited;
    rst_n     = 1'b0;
    bus_req   = 1'b0;
    bus_addr  = '0;
    bus_we    = 1'b0;
    bus_wdata = '0;
    intr_ext  = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    mark         = 0;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;

    check_value({29'b0, bus_rvalid, irq, msip}, '0, "rvalid, irq and msip after reset");
    for (int t = 0; t < `PERIPH_NUM_TIMERS; t++) begin
      for (int r = 0; r < 4; r++) begin
        check_reg(periph_pkg::slot_t'(t), periph_pkg::reg_idx_t'(r), '0, "timer reset value");
      end
    end
    for (int r = 0; r < 4; r++) begin
      check_reg(irq_slot, periph_pkg::reg_idx_t'(r), '0, "controller reset value");
    end
    finish_test("reset_state");

    // Write and read pipelined in consecutive cycles
    for (int k = 0; k < 8; k++) begin
      val = xorshift();
      write_reg(periph_pkg::slot_t'(k % 4), periph_pkg::TMR_COUNT, val);
      check_reg(periph_pkg::slot_t'(k % 4), periph_pkg::TMR_COUNT, val, "count write then read");
    end
    finish_test("bus_protocol");

    for (int t = 0; t < `PERIPH_NUM_TIMERS; t++) begin
      val = xorshift();
      write_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_COMPARE, val);
      check_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_COMPARE, val, "timer compare");
    end
    val = xorshift();
    write_reg(irq_slot, periph_pkg::IRQ_ENABLE, val);
    // One enable bit per source
    val = val & ((32'd1 << `PERIPH_NUM_IRQ_SRC) - 32'd1);
    check_reg(irq_slot, periph_pkg::IRQ_ENABLE, val, "interrupt enable");
    write_reg(irq_slot, periph_pkg::IRQ_ENABLE, '0);
    for (int s = `PERIPH_NUM_TIMERS; s < `PERIPH_IRQ_SLOT; s++) begin
      write_reg(periph_pkg::slot_t'(s), periph_pkg::TMR_CTRL, xorshift());
      check_reg(periph_pkg::slot_t'(s), periph_pkg::TMR_CTRL, '0, "unmapped slot");
    end
    finish_test("register_access");

    for (int t = 0; t < `PERIPH_NUM_TIMERS; t++) begin
      c = 2 + int'(xorshift() % 8);
      write_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_COMPARE, c);
      write_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_COUNT, '0);
      write_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_CTRL, 32'd1);
      waited = 0;
      val = '0;
      while (val[0] !== 1'b1 && waited < c + 2) begin
        access(1'b0, periph_pkg::slot_t'(t), periph_pkg::TMR_STATUS, '0, val);
        waited++;
      end
      if (val[0] !== 1'b1) begin
        errors++;
        $display("Timer %0d did not expire within %0d cycles", t, c + 1);
      end
      write_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_CTRL, '0);
      check_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_STATUS, 32'd1, "expired status");
      // Timer 1 stays expired as interrupt ID 2
      if (t != 1) begin
        write_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_STATUS, 32'd1);
        check_reg(periph_pkg::slot_t'(t), periph_pkg::TMR_STATUS, '0, "status after clear");
      end
    end
    finish_test("timer_expiry");

    // External line 2 is ID 7
    intr_ext = 4'b0100;
    src = (32'(intr_ext) << (1 + `PERIPH_NUM_TIMERS)) | (32'd1 << 2);
    write_reg(irq_slot, periph_pkg::IRQ_ENABLE, src);
    check_value({31'b0, irq}, 32'd1, "irq_o with enabled sources");
    check_reg(irq_slot, periph_pkg::IRQ_STATUS, src, "interrupt status");
    check_reg(irq_slot, periph_pkg::IRQ_ENABLE, src, "interrupt enable");
    check_reg(irq_slot, periph_pkg::IRQ_CLAIM, 32'd2, "claim with timer and line");
    write_reg(irq_slot, periph_pkg::IRQ_ENABLE, 32'd1 << 7);
    check_reg(irq_slot, periph_pkg::IRQ_CLAIM, 32'd7, "claim with line only");
    write_reg(irq_slot, periph_pkg::IRQ_ENABLE, '0);
    check_value({31'b0, irq}, '0, "irq_o with enables cleared");
    check_reg(irq_slot, periph_pkg::IRQ_CLAIM, '0, "claim with no enabled source");
    intr_ext = '0;
    finish_test("interrupt_routing");

    write_reg(irq_slot, periph_pkg::IRQ_SOFT, 32'd1);
    check_value({31'b0, msip}, 32'd1, "msip_o after set");
    check_reg(irq_slot, periph_pkg::IRQ_SOFT, 32'd1, "software interrupt register");
    write_reg(irq_slot, periph_pkg::IRQ_SOFT, '0);
    check_value({31'b0, msip}, '0, "msip_o after clear");
    // Idle cycles let the last bus and msip assertions evaluate
    repeat (2) @(posedge clk);
    #(drive_delay);
    finish_test("software_interrupt");

    $display("tests %0d, failed %0d, failed checks %0d", tests_run, tests_failed, fail_total());
    if (fail_total() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verification/periph_subsystem_assertions.sv
////////////////////////////////////////////////////////////////////////////
// Reset, bus protocol, interrupt and software interrupt assertions
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_subsystem_assertions (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      bus_req_i,
  input logic                      bus_gnt_i,
  input logic                      bus_rvalid_i,
  input logic [`PERIPH_DATA_W-1:0] bus_rdata_i,
  input logic                      irq_i,
  input logic                      msip_i,
  input logic                      irq_wr_i,
  input logic                      irq_rd_i,
  input periph_pkg::reg_idx_t      reg_idx_i,
  input logic [`PERIPH_DATA_W-1:0] wdata_i
);

  int unsigned               fail_count = 0;
  logic                      stat_rsp_q;
  logic                      en_rsp_q;
  logic                      stat_prev_q;
  logic [`PERIPH_DATA_W-1:0] stat_data_q;

  // Which controller register the current response carries
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stat_rsp_q  <= 1'b0;
      en_rsp_q    <= 1'b0;
      stat_prev_q <= 1'b0;
      stat_data_q <= '0;
    end else begin
      stat_rsp_q  <= irq_rd_i && (reg_idx_i == periph_pkg::IRQ_STATUS);
      en_rsp_q    <= irq_rd_i && (reg_idx_i == periph_pkg::IRQ_ENABLE);
      stat_prev_q <= stat_rsp_q;
      stat_data_q <= bus_rdata_i;
    end
  end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !bus_rvalid_i && !irq_i && !msip_i)
    else begin
      fail_count++;
      $error("outputs active while reset is held");
    end

  gnt_equals_req: assert property (@(posedge clk_i) bus_gnt_i == bus_req_i)
    else begin
      fail_count++;
      $error("grant differs from request");
    end

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_gnt_i |=> bus_rvalid_i)
    else begin
      fail_count++;
      $error("no read-valid one cycle after a grant");
    end

  no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !bus_gnt_i |=> !bus_rvalid_i)
    else begin
      fail_count++;
      $error("read-valid without a grant");
    end

  // Status response directly followed by an enable response
  irq_matches_bus: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    en_rsp_q && stat_prev_q |-> irq_i == |(bus_rdata_i & stat_data_q))
    else begin
      fail_count++;
      $error("irq_o does not match status and enable read over the bus");
    end

  msip_follows_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_wr_i && (reg_idx_i == periph_pkg::IRQ_SOFT) |=> msip_i == $past(wdata_i[0]))
    else begin
      fail_count++;
      $error("msip_o does not follow the software interrupt write");
    end

endmodule

bind periph_subsystem periph_subsystem_assertions assertions_i (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .bus_req_i    (bus_req_i),
  .bus_gnt_i    (bus_gnt_o),
  .bus_rvalid_i (bus_rvalid_o),
  .bus_rdata_i  (bus_rdata_o),
  .irq_i        (irq_o),
  .msip_i       (msip_o),
  .irq_wr_i     (irq_wr),
  .irq_rd_i     (irq_rd),
  .reg_idx_i    (reg_idx),
  .wdata_i      (wdata)
);

// File: rtl/periph_subsystem.sv
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem top with bus adapter, decoder, timers and
// interrupt controller
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_subsystem (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  input  logic                           bus_req_i,
  input  logic [`PERIPH_ADDR_W-1:0]      bus_addr_i,
  input  logic                           bus_we_i,
  input  logic [`PERIPH_DATA_W-1:0]      bus_wdata_i,
  output logic                           bus_gnt_o,
  output logic                           bus_rvalid_o,
  output logic [`PERIPH_DATA_W-1:0]      bus_rdata_o,

  input  logic [`PERIPH_NUM_EXT_INT-1:0] intr_ext_i,
  output logic                           irq_o,
  output logic                           msip_o
);

  logic                                              reg_wr;
  logic                                              reg_rd;
  logic [`PERIPH_ADDR_W-1:0]                         reg_addr;
  logic [`PERIPH_DATA_W-1:0]                         reg_wdata;
  logic [`PERIPH_DATA_W-1:0]                         reg_rdata;
  logic [`PERIPH_REG_W-1:0]                          reg_idx;
  logic [`PERIPH_DATA_W-1:0]                         wdata;
  logic [`PERIPH_NUM_TIMERS-1:0]                     tmr_wr;
  logic [`PERIPH_NUM_TIMERS-1:0]                     tmr_rd;
  logic [`PERIPH_NUM_TIMERS-1:0][`PERIPH_DATA_W-1:0] tmr_rdata;
  logic [`PERIPH_NUM_TIMERS-1:0]                     tmr_irq;
  logic                                              irq_wr;
  logic                                              irq_rd;
  logic [`PERIPH_DATA_W-1:0]                         irq_rdata;

  periph_bus_adapter bus_adapter_i (
    .clk_i,
    .rst_n_i,
    .bus_req_i,
    .bus_addr_i,
    .bus_we_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .reg_wr_o    (reg_wr),
    .reg_rd_o    (reg_rd),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  periph_decode decode_i (
    .reg_wr_i    (reg_wr),
    .reg_rd_i    (reg_rd),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .reg_idx_o   (reg_idx),
    .wdata_o     (wdata),
    .tmr_wr_o    (tmr_wr),
    .tmr_rd_o    (tmr_rd),
    .tmr_rdata_i (tmr_rdata),
    .irq_wr_o    (irq_wr),
    .irq_rd_o    (irq_rd),
    .irq_rdata_i (irq_rdata)
  );

  for (genvar i = 0; i < `PERIPH_NUM_TIMERS; i++) begin : gen_timer
    periph_timer timer_i (
      .clk_i,
      .rst_n_i,
      .wr_i      (tmr_wr[i]),
      .rd_i      (tmr_rd[i]),
      .reg_idx_i (reg_idx),
      .wdata_i   (wdata),
      .rdata_o   (tmr_rdata[i]),
      .irq_o     (tmr_irq[i])
    );
  end

  periph_irq_ctrl irq_ctrl_i (
    .clk_i,
    .rst_n_i,
    .wr_i       (irq_wr),
    .rd_i       (irq_rd),
    .reg_idx_i  (reg_idx),
    .wdata_i    (wdata),
    .rdata_o    (irq_rdata),
    .tmr_irq_i  (tmr_irq),
    .intr_ext_i,
    .irq_o,
    .msip_o
  );

endmodule

// File: irq/periph_irq_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Interrupt controller with enable mask, claim and software interrupt
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_irq_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          wr_i,
  input  logic                          rd_i,
  input  periph_pkg::reg_idx_t          reg_idx_i,
  input  logic [`PERIPH_DATA_W-1:0]     wdata_i,
  output logic [`PERIPH_DATA_W-1:0]     rdata_o,
  input  logic [`PERIPH_NUM_TIMERS-1:0] tmr_irq_i,
  input  logic [`PERIPH_NUM_EXT_INT-1:0] intr_ext_i,
  output logic                          irq_o,
  output logic                          msip_o
);

  localparam int unsigned NSrc = `PERIPH_NUM_IRQ_SRC;

  periph_pkg::irq_reg_e reg_sel;
  logic [NSrc-1:0]      src;
  logic [NSrc-1:0]      enable_q;
  logic [NSrc-1:0]      active;
  periph_pkg::irq_id_t  claim;

  assign reg_sel = periph_pkg::irq_reg_e'(reg_idx_i);

  // ID 0 means no interrupt, timers follow, then external lines
  assign src    = {intr_ext_i, tmr_irq_i, 1'b0};
  assign active = src & enable_q;
  assign irq_o  = |active;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= '0;
      msip_o   <= 1'b0;
    end else if (wr_i) begin
      case (reg_sel)
        periph_pkg::IRQ_ENABLE: enable_q <= wdata_i[NSrc-1:0];
        periph_pkg::IRQ_SOFT:   msip_o <= wdata_i[0];
        default: ;
      endcase
    end
  end

  // Lowest active ID wins, scan downward so it is written last
  always_comb begin
    claim = '0;
    for (int i = NSrc - 1; i > 0; i--) begin
      if (active[i]) claim = periph_pkg::irq_id_t'(i);
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rd_i) begin
      case (reg_sel)
        periph_pkg::IRQ_STATUS: rdata_o[NSrc-1:0] = src;
        periph_pkg::IRQ_ENABLE: rdata_o[NSrc-1:0] = enable_q;
        periph_pkg::IRQ_CLAIM:  rdata_o[$bits(claim)-1:0] = claim;
        periph_pkg::IRQ_SOFT:   rdata_o[0] = msip_o;
        default:                rdata_o = '0;
      endcase
    end
  end

endmodule

// File: timer/periph_timer.sv
////////////////////////////////////////////////////////////////////////////
// Interval timer with enable, compare, count and expired status
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_timer (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wr_i,
  input  logic                      rd_i,
  input  periph_pkg::reg_idx_t      reg_idx_i,
  input  logic [`PERIPH_DATA_W-1:0] wdata_i,
  output logic [`PERIPH_DATA_W-1:0] rdata_o,
  output logic                      irq_o
);

  periph_pkg::timer_reg_e    reg_sel;
  logic                      enable_q;
  logic [`PERIPH_DATA_W-1:0] compare_q;
  logic [`PERIPH_DATA_W-1:0] count_q;
  logic                      expired_q;
  logic                      hit;

  assign reg_sel = periph_pkg::timer_reg_e'(reg_idx_i);

  // Count reached compare this cycle
  assign hit = enable_q && (count_q == compare_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q  <= 1'b0;
      compare_q <= '0;
    end else if (wr_i) begin
      case (reg_sel)
        periph_pkg::TMR_CTRL:    enable_q <= wdata_i[0];
        periph_pkg::TMR_COMPARE: compare_q <= wdata_i;
        default: ;
      endcase
    end
  end

  // Software write to the count overrides the wrap
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (wr_i && reg_sel == periph_pkg::TMR_COUNT) begin
      count_q <= wdata_i;
    end else if (hit) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  // A new expiry wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      expired_q <= 1'b0;
    end else if (hit) begin
      expired_q <= 1'b1;
    end else if (wr_i && reg_sel == periph_pkg::TMR_STATUS && wdata_i[0]) begin
      expired_q <= 1'b0;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rd_i) begin
      case (reg_sel)
        periph_pkg::TMR_CTRL:    rdata_o[0] = enable_q;
        periph_pkg::TMR_COMPARE: rdata_o = compare_q;
        periph_pkg::TMR_COUNT:   rdata_o = count_q;
        periph_pkg::TMR_STATUS:  rdata_o[0] = expired_q;
        default:                 rdata_o = '0;
      endcase
    end
  end

  assign irq_o = expired_q;

endmodule

// File: rtl/periph_decode.sv
////////////////////////////////////////////////////////////////////////////
// Slot decoder with strobe steering and read data mux
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_decode (
  input  logic                                              reg_wr_i,
  input  logic                                              reg_rd_i,
  input  logic [`PERIPH_ADDR_W-1:0]                         reg_addr_i,
  input  logic [`PERIPH_DATA_W-1:0]                         reg_wdata_i,
  output logic [`PERIPH_DATA_W-1:0]                         reg_rdata_o,
  output periph_pkg::reg_idx_t                              reg_idx_o,
  output logic [`PERIPH_DATA_W-1:0]                         wdata_o,
  output logic [`PERIPH_NUM_TIMERS-1:0]                     tmr_wr_o,
  output logic [`PERIPH_NUM_TIMERS-1:0]                     tmr_rd_o,
  input  logic [`PERIPH_NUM_TIMERS-1:0][`PERIPH_DATA_W-1:0] tmr_rdata_i,
  output logic                                              irq_wr_o,
  output logic                                              irq_rd_o,
  input  logic [`PERIPH_DATA_W-1:0]                         irq_rdata_i
);

  periph_pkg::slot_t slot;
  logic              irq_sel;

  assign slot      = reg_addr_i[`PERIPH_SLOT_LSB +: `PERIPH_SLOT_W];
  assign reg_idx_o = reg_addr_i[`PERIPH_REG_LSB +: `PERIPH_REG_W];
  assign wdata_o   = reg_wdata_i;

  // Timers occupy the lowest slots
  for (genvar i = 0; i < `PERIPH_NUM_TIMERS; i++) begin : gen_tmr_sel
    assign tmr_wr_o[i] = reg_wr_i && (slot == periph_pkg::slot_t'(i));
    assign tmr_rd_o[i] = reg_rd_i && (slot == periph_pkg::slot_t'(i));
  end

  assign irq_sel  = (slot == periph_pkg::slot_t'(`PERIPH_IRQ_SLOT));
  assign irq_wr_o = reg_wr_i & irq_sel;
  assign irq_rd_o = reg_rd_i & irq_sel;

  // Unmapped slots read zero
  always_comb begin
    reg_rdata_o = '0;
    for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
      if (slot == periph_pkg::slot_t'(i)) reg_rdata_o = tmr_rdata_i[i];
    end
    if (irq_sel) reg_rdata_o = irq_rdata_i;
  end

endmodule

// File: rtl/periph_bus_adapter.sv
////////////////////////////////////////////////////////////////////////////
// Core-side bus port to register strobes, with one-cycle read response
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "periph_defines.svh"

module periph_bus_adapter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // Core side
  input  logic                      bus_req_i,
  input  logic [`PERIPH_ADDR_W-1:0] bus_addr_i,
  input  logic                      bus_we_i,
  input  logic [`PERIPH_DATA_W-1:0] bus_wdata_i,
  output logic                      bus_gnt_o,
  output logic                      bus_rvalid_o,
  output logic [`PERIPH_DATA_W-1:0] bus_rdata_o,

  // Register side
  output logic                      reg_wr_o,
  output logic                      reg_rd_o,
  output logic [`PERIPH_ADDR_W-1:0] reg_addr_o,
  output logic [`PERIPH_DATA_W-1:0] reg_wdata_o,
  input  logic [`PERIPH_DATA_W-1:0] reg_rdata_i
);

  // No back-pressure, every request is granted at once
  assign bus_gnt_o = bus_req_i;

  assign reg_wr_o    = bus_req_i & bus_we_i;
  assign reg_rd_o    = bus_req_i & ~bus_we_i;
  assign reg_addr_o  = bus_addr_i;
  assign reg_wdata_o = bus_wdata_i;

  // Response pulse one cycle after each grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_rvalid_o <= 1'b0;
    end else begin
      bus_rvalid_o <= bus_req_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (reg_rd_o) begin
      bus_rdata_o <= reg_rdata_i;
    end else begin
      bus_rdata_o <= '0;
    end
  end

endmodule

// File: common/periph_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Slot, register index and interrupt ID types with register maps
////////////////////////////////////////////////////////////////////////////
`include "periph_defines.svh"

package periph_pkg;

  typedef logic [`PERIPH_SLOT_W-1:0] slot_t;
  typedef logic [`PERIPH_REG_W-1:0] reg_idx_t;

  // Timer register map
  typedef enum logic [`PERIPH_REG_W-1:0] {
    TMR_CTRL    = 2'd0,
    TMR_COMPARE = 2'd1,
    TMR_COUNT   = 2'd2,
    TMR_STATUS  = 2'd3
  } timer_reg_e;

  // Interrupt controller register map
  typedef enum logic [`PERIPH_REG_W-1:0] {
    IRQ_STATUS = 2'd0,
    IRQ_ENABLE = 2'd1,
    IRQ_CLAIM  = 2'd2,
    IRQ_SOFT   = 2'd3
  } irq_reg_e;

  typedef logic [$clog2(`PERIPH_NUM_IRQ_SRC)-1:0] irq_id_t;

endpackage

// File: common/periph_defines.svh
////////////////////////////////////////////////////////////////////////////
// Sizes, address fields and slot numbers of the peripheral subsystem
////////////////////////////////////////////////////////////////////////////
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Instance counts
`define PERIPH_NUM_TIMERS 4
`define PERIPH_NUM_EXT_INT 4

// Register bus widths
`define PERIPH_DATA_W 32
`define PERIPH_ADDR_W 32

// Address fields, slot in bits 11:8 and word index in bits 3:2
`define PERIPH_SLOT_LSB 8
`define PERIPH_SLOT_W 4
`define PERIPH_REG_LSB 2
`define PERIPH_REG_W 2

// Interrupt controller slot and source count, ID 0 reserved
`define PERIPH_IRQ_SLOT 15
`define PERIPH_NUM_IRQ_SRC (1 + `PERIPH_NUM_TIMERS + `PERIPH_NUM_EXT_INT)

`endif
